// ==== filelist.f ====
lv_pkg.sv
owt_rx_if.sv
owt_rx.sv
lv_hv_shadow_reg.sv
owt_link_monitor.sv
lv_hv_link_top.sv
tb_lv_hv_link.sv

// ==== tb_lv_hv_link.sv ====
`timescale 1ns/1ps

module tb_lv_hv_link;

    localparam int BIT_CYC      = 8;
    localparam int LINK_TIMEOUT = 2000;
    localparam int SETTLE_CYC   = 64;
    localparam int NUM_REGS     = 8;

    logic              i_clk;
    logic              i_arst_n;
    logic              i_owt_rxd;
    lv_pkg::reg_data_t o_reg_status1;
    lv_pkg::reg_data_t o_reg_status2;
    lv_pkg::reg_data_t o_reg_status3;
    lv_pkg::reg_data_t o_reg_status4;
    lv_pkg::reg_data_t o_reg_bist1;
    lv_pkg::reg_data_t o_reg_bist2;
    lv_pkg::adc_data_t o_reg_adc1;
    lv_pkg::adc_data_t o_reg_adc2;
    logic              o_link_ok;
    lv_pkg::err_cnt_t  o_err_cnt;

    // model of status1..4, bist1..2, adc1 and adc2
    lv_pkg::reg_data_t exp_reg [NUM_REGS];
    lv_pkg::err_cnt_t  exp_err;
    logic              exp_link;
    logic [31:0]       lfsr;
    int                err_total;
    int                test_errs_start;
    int                test_num;
    int                tests_failed;

    string reg_name [NUM_REGS] = '{"o_reg_status1", "o_reg_status2", "o_reg_status3",
                                   "o_reg_status4", "o_reg_bist1", "o_reg_bist2",
                                   "o_reg_adc1", "o_reg_adc2"};
    lv_pkg::reg_addr_t wr_addrs [6] = '{lv_pkg::ADDR_STATUS1, lv_pkg::ADDR_STATUS2,
                                        lv_pkg::ADDR_STATUS3, lv_pkg::ADDR_STATUS4,
                                        lv_pkg::ADDR_BIST1, lv_pkg::ADDR_BIST2};

    lv_hv_link_top #(
        .BIT_CYC       (BIT_CYC),
        .LINK_TIMEOUT  (LINK_TIMEOUT)
    ) lv_hv_link_top_i (
        .i_clk         (i_clk),
        .i_arst_n      (i_arst_n),
        .i_owt_rxd     (i_owt_rxd),
        .o_reg_status1 (o_reg_status1),
        .o_reg_status2 (o_reg_status2),
        .o_reg_status3 (o_reg_status3),
        .o_reg_status4 (o_reg_status4),
        .o_reg_bist1   (o_reg_bist1),
        .o_reg_bist2   (o_reg_bist2),
        .o_reg_adc1    (o_reg_adc1),
        .o_reg_adc2    (o_reg_adc2),
        .o_link_ok     (o_link_ok),
        .o_err_cnt     (o_err_cnt)
    );

    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    //====================
    // stimulus helpers
    //====================
    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            val  = {val[30:0], lfsr[0]};
        end
    endtask

    task automatic drive_bit(input logic b);
        @(posedge i_clk);
        i_owt_rxd <= b;
        repeat (BIT_CYC - 1) @(posedge i_clk);
    endtask

    task automatic send_frame(input lv_pkg::owt_cmd_t cmd, input lv_pkg::owt_data_t data,
                              input logic flip_parity, input logic stop_val);
        logic [27:0] payload;
        payload = {cmd, data};
        drive_bit(1'b0);
        for (int i = 27; i >= 0; i--) begin
            drive_bit(payload[i]);
        end
        drive_bit((^payload) ^ flip_parity);
        drive_bit(stop_val);
        // idle gap so the frame is fully taken
        drive_bit(1'b1);
        drive_bit(1'b1);
    endtask

    //====================
    // reference model
    //====================
    function automatic void model_frame(input lv_pkg::owt_cmd_t cmd,
                                        input lv_pkg::owt_data_t data, input logic bad);
        if (bad) begin
            if (exp_err != '1) exp_err = exp_err + 1'b1;
            return;
        end
        exp_link = 1'b1;
        if (!cmd[7]) return;
        case (cmd[6:0])
            lv_pkg::ADDR_STATUS1: exp_reg[0] = data[9:0];
            lv_pkg::ADDR_STATUS2: exp_reg[1] = data[9:0];
            lv_pkg::ADDR_STATUS3: exp_reg[2] = data[9:0];
            lv_pkg::ADDR_STATUS4: exp_reg[3] = data[9:0];
            lv_pkg::ADDR_BIST1:   exp_reg[4] = data[9:0];
            lv_pkg::ADDR_BIST2:   exp_reg[5] = data[9:0];
            lv_pkg::ADDR_ADC: begin
                exp_reg[6] = data[9:0];
                exp_reg[7] = data[19:10];
            end
            default: begin
            end
        endcase
    endfunction

    //====================
    // checking
    //====================
    function automatic lv_pkg::reg_data_t dut_reg(input int idx);
        case (idx)
            0: return o_reg_status1;
            1: return o_reg_status2;
            2: return o_reg_status3;
            3: return o_reg_status4;
            4: return o_reg_bist1;
            5: return o_reg_bist2;
            6: return o_reg_adc1;
            default: return o_reg_adc2;
        endcase
    endfunction

    function automatic logic outputs_match();
        logic ok;
        ok = (o_link_ok === exp_link) && (o_err_cnt === exp_err);
        for (int i = 0; i < NUM_REGS; i++) begin
            if (dut_reg(i) !== exp_reg[i]) ok = 1'b0;
        end
        return ok;
    endfunction

    task automatic check_outputs();
        int cyc;
        cyc = 0;
        @(negedge i_clk);
        while (!outputs_match() && cyc < SETTLE_CYC) begin
            @(negedge i_clk);
            cyc++;
        end
        for (int i = 0; i < NUM_REGS; i++) begin
            if (dut_reg(i) !== exp_reg[i]) begin
                $display("Fail %s expected %h actual %h", reg_name[i], exp_reg[i], dut_reg(i));
                err_total++;
            end
        end
        if (o_link_ok !== exp_link) begin
            $display("Fail o_link_ok expected %h actual %h", exp_link, o_link_ok);
            err_total++;
        end
        if (o_err_cnt !== exp_err) begin
            $display("Fail o_err_cnt expected %h actual %h", exp_err, o_err_cnt);
            err_total++;
        end
    endtask

    task automatic run_frame(input lv_pkg::owt_cmd_t cmd, input lv_pkg::owt_data_t data,
                             input logic flip_parity, input logic zero_stop);
        send_frame(cmd, data, flip_parity, ~zero_stop);
        model_frame(cmd, data, flip_parity | zero_stop);
        check_outputs();
    endtask

    task automatic random_frame(input logic wr, input lv_pkg::reg_addr_t addr,
                                input logic flip_parity, input logic zero_stop);
        logic [31:0] rnd;
        take_bits(lv_pkg::OWT_ADCD_BIT_NUM, rnd);
        run_frame({wr, addr}, rnd[19:0], flip_parity, zero_stop);
    endtask

    task automatic end_test(input string name);
        test_num++;
        if (err_total == test_errs_start) begin
            $display("test %0d %s: ok", test_num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d mismatches", test_num, name,
                     err_total - test_errs_start);
        end
        test_errs_start = err_total;
    endtask

    //====================
    // test sequence
    //====================
    initial begin
        int idle_cyc;
        i_arst_n  = 1'b0;
        i_owt_rxd = 1'b1;
        lfsr      = 32'h5092_2bdc;
        exp_err   = '0;
        exp_link  = 1'b0;
        err_total = 0;
        test_num  = 0;
        tests_failed    = 0;
        test_errs_start = 0;
        for (int i = 0; i < NUM_REGS; i++) begin
            exp_reg[i] = '0;
        end
        repeat (3) @(posedge i_clk);
        i_arst_n <= 1'b1;

        check_outputs();
        end_test("reset values");

        for (int i = 0; i < 6; i++) begin
            random_frame(1'b1, wr_addrs[i], 1'b0, 1'b0);
        end
        end_test("status and bist writes");

        random_frame(1'b1, lv_pkg::ADDR_ADC, 1'b0, 1'b0);
        random_frame(1'b1, lv_pkg::ADDR_ADC, 1'b0, 1'b0);
        end_test("adc pair write");

        random_frame(1'b1, lv_pkg::ADDR_STATUS1, 1'b1, 1'b0);
        random_frame(1'b1, lv_pkg::ADDR_BIST1, 1'b0, 1'b1);
        end_test("bad parity and stop");

        random_frame(1'b0, lv_pkg::ADDR_STATUS2, 1'b0, 1'b0);
        random_frame(1'b1, 7'h02, 1'b0, 1'b0);
        end_test("read and unmapped frames");

        random_frame(1'b1, lv_pkg::ADDR_STATUS3, 1'b0, 1'b0);
        idle_cyc = 0;
        while (o_link_ok && idle_cyc < 2 * LINK_TIMEOUT) begin
            @(negedge i_clk);
            idle_cyc++;
        end
        if (o_link_ok) begin
            $display("link_ok stayed high for %0d idle cycles", idle_cyc);
            err_total++;
        end else if (idle_cyc < LINK_TIMEOUT - SETTLE_CYC) begin
            $display("link_ok fell after only %0d idle cycles", idle_cyc);
            err_total++;
        end
        exp_link = 1'b0;
        check_outputs();
        random_frame(1'b1, lv_pkg::ADDR_BIST2, 1'b0, 1'b0);
        end_test("link loss and recovery");

        $display("tests run %0d, tests failed %0d, mismatches %0d",
                 test_num, tests_failed, err_total);
        if (err_total == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== lv_hv_link_top.sv ====
`timescale 1ns/1ps

module lv_hv_link_top #(
    parameter int BIT_CYC      = 8,
    parameter int LINK_TIMEOUT = 4096
)(
    input  logic              i_clk,
    input  logic              i_arst_n,
    input  logic              i_owt_rxd,
    output lv_pkg::reg_data_t o_reg_status1,
    output lv_pkg::reg_data_t o_reg_status2,
    output lv_pkg::reg_data_t o_reg_status3,
    output lv_pkg::reg_data_t o_reg_status4,
    output lv_pkg::reg_data_t o_reg_bist1,
    output lv_pkg::reg_data_t o_reg_bist2,
    output lv_pkg::adc_data_t o_reg_adc1,
    output lv_pkg::adc_data_t o_reg_adc2,
    output logic              o_link_ok,
    output lv_pkg::err_cnt_t  o_err_cnt
);

    // received frames go from one producer to two sinks
    owt_rx_if owt_rx_if_i ();

    //====================
    // serial receiver
    //====================
    owt_rx #(
        .BIT_CYC   (BIT_CYC)
    ) owt_rx_i (
        .i_clk     (i_clk),
        .i_arst_n  (i_arst_n),
        .i_owt_rxd (i_owt_rxd),
        .rx        (owt_rx_if_i.rx)
    );

    //====================
    // shadow bank
    //====================
    lv_hv_shadow_reg lv_hv_shadow_reg_i (
        .i_clk         (i_clk),
        .i_arst_n      (i_arst_n),
        .rx            (owt_rx_if_i.sink),
        .o_reg_status1 (o_reg_status1),
        .o_reg_status2 (o_reg_status2),
        .o_reg_status3 (o_reg_status3),
        .o_reg_status4 (o_reg_status4),
        .o_reg_bist1   (o_reg_bist1),
        .o_reg_bist2   (o_reg_bist2),
        .o_reg_adc1    (o_reg_adc1),
        .o_reg_adc2    (o_reg_adc2)
    );

    //====================
    // link health
    //====================
    owt_link_monitor #(
        .LINK_TIMEOUT (LINK_TIMEOUT)
    ) owt_link_monitor_i (
        .i_clk     (i_clk),
        .i_arst_n  (i_arst_n),
        .rx        (owt_rx_if_i.sink),
        .o_link_ok (o_link_ok),
        .o_err_cnt (o_err_cnt)
    );

endmodule

// ==== owt_link_monitor.sv ====
`timescale 1ns/1ps

module owt_link_monitor #(
    parameter int LINK_TIMEOUT = 4096
)(
    input  logic             i_clk,
    input  logic             i_arst_n,
    owt_rx_if.sink           rx,
    output logic             o_link_ok,
    output lv_pkg::err_cnt_t o_err_cnt
);

    localparam int TMR_W = $clog2(LINK_TIMEOUT);

    logic             good_frame;
    logic             bad_frame;
    logic [TMR_W-1:0] idle_tmr;
    logic             tmr_done;

    // reads with good parity also count as good
    assign good_frame = rx.ack & ~rx.status;
    assign bad_frame  = rx.ack & rx.status;

    //====================
    // bad-frame counter
    //====================
    // holds at all ones
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_err_cnt <= '0;
        end else if (bad_frame && o_err_cnt != '1) begin
            o_err_cnt <= o_err_cnt + 1'b1;
        end
    end

    //====================
    // link-loss timer
    //====================
    assign tmr_done = (idle_tmr == TMR_W'(LINK_TIMEOUT - 1));

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            idle_tmr <= '0;
        end else if (good_frame) begin
            idle_tmr <= '0;
        end else if (!tmr_done) begin
            idle_tmr <= idle_tmr + 1'b1;
        end
    end

    // timer parks at the limit until the next good frame
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_link_ok <= 1'b0;
        end else if (good_frame) begin
            o_link_ok <= 1'b1;
        end else if (tmr_done) begin
            o_link_ok <= 1'b0;
        end
    end

endmodule

// ==== lv_hv_shadow_reg.sv ====
`timescale 1ns/1ps

module lv_hv_shadow_reg (
    input  logic              i_clk,
    input  logic              i_arst_n,
    owt_rx_if.sink            rx,
    output lv_pkg::reg_data_t o_reg_status1,
    output lv_pkg::reg_data_t o_reg_status2,
    output lv_pkg::reg_data_t o_reg_status3,
    output lv_pkg::reg_data_t o_reg_status4,
    output lv_pkg::reg_data_t o_reg_bist1,
    output lv_pkg::reg_data_t o_reg_bist2,
    output lv_pkg::adc_data_t o_reg_adc1,
    output lv_pkg::adc_data_t o_reg_adc2
);

    logic              reg_wen;
    lv_pkg::reg_addr_t reg_addr;
    lv_pkg::reg_data_t reg_wdata;
    lv_pkg::adc_data_t adc_lo;
    lv_pkg::adc_data_t adc_hi;

    //====================
    // write decode
    //====================
    // good frame with the write flag set
    assign reg_wen  = rx.ack & ~rx.status & rx.cmd[lv_pkg::OWT_CMD_BIT_NUM-1];
    assign reg_addr = rx.cmd[lv_pkg::REG_AW-1:0];

    assign reg_wdata = rx.data[lv_pkg::REG_DW-1:0];

    // two samples packed in one frame with adc2 on top
    assign adc_lo = rx.data[lv_pkg::ADC_DW-1:0];
    assign adc_hi = rx.data[lv_pkg::OWT_ADCD_BIT_NUM-1 -: lv_pkg::ADC_DW];

    //====================
    // status registers
    //====================
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_reg_status1 <= '0;
            o_reg_status2 <= '0;
            o_reg_status3 <= '0;
            o_reg_status4 <= '0;
        end else if (reg_wen) begin
            case (reg_addr)
                lv_pkg::ADDR_STATUS1: o_reg_status1 <= reg_wdata;
                lv_pkg::ADDR_STATUS2: o_reg_status2 <= reg_wdata;
                lv_pkg::ADDR_STATUS3: o_reg_status3 <= reg_wdata;
                lv_pkg::ADDR_STATUS4: o_reg_status4 <= reg_wdata;
                default: begin
                end
            endcase
        end
    end

    //====================
    // bist registers
    //====================
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_reg_bist1 <= '0;
            o_reg_bist2 <= '0;
        end else if (reg_wen) begin
            case (reg_addr)
                lv_pkg::ADDR_BIST1: o_reg_bist1 <= reg_wdata;
                lv_pkg::ADDR_BIST2: o_reg_bist2 <= reg_wdata;
                default: begin
                end
            endcase
        end
    end

    //====================
    // adc sample pair
    //====================
    // both samples update on the same edge
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_reg_adc1 <= '0;
            o_reg_adc2 <= '0;
        end else if (reg_wen && reg_addr == lv_pkg::ADDR_ADC) begin
            o_reg_adc1 <= adc_lo;
            o_reg_adc2 <= adc_hi;
        end
    end

endmodule

// ==== owt_rx.sv ====
`timescale 1ns/1ps

module owt_rx #(
    parameter int BIT_CYC = 8
)(
    input  logic   i_clk,
    input  logic   i_arst_n,
    input  logic   i_owt_rxd,
    owt_rx_if.rx   rx
);

    localparam int PAY_W = lv_pkg::OWT_CMD_BIT_NUM + lv_pkg::OWT_ADCD_BIT_NUM;
    localparam int CNT_W = $clog2(BIT_CYC) + 1;
    localparam int IDX_W = $clog2(PAY_W + 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_START,
        ST_BITS,
        ST_STOP
    } rx_state_t;

    rx_state_t          state;
    rx_state_t          state_nxt;
    logic [1:0]         rxd_sync;
    logic               rxd_s;
    logic [CNT_W-1:0]   bit_cnt;
    logic [IDX_W-1:0]   bit_idx;
    logic               bit_end;
    logic               half_end;
    logic               cnt_clr;
    logic               bit_smp;
    logic               stop_smp;
    logic [PAY_W-1:0]   shift_q;
    logic               parity_acc;

    //====================
    // input synchronizer
    //====================
    // line idles high
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            rxd_sync <= 2'b11;
        end else begin
            rxd_sync <= {rxd_sync[0], i_owt_rxd};
        end
    end

    assign rxd_s = rxd_sync[1];

    //====================
    // bit timing and fsm
    //====================
    assign bit_end  = (bit_cnt == CNT_W'(BIT_CYC - 1));
    assign half_end = (bit_cnt == CNT_W'(BIT_CYC / 2 - 1));

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (!rxd_s) state_nxt = ST_START;
            end
            ST_START: begin
                // start bit must still be low at mid-bit
                if (half_end) state_nxt = rxd_s ? ST_IDLE : ST_BITS;
            end
            ST_BITS: begin
                // last sample here is the parity bit
                if (bit_end && bit_idx == IDX_W'(PAY_W)) state_nxt = ST_STOP;
            end
            ST_STOP: begin
                if (bit_end) state_nxt = ST_IDLE;
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    assign cnt_clr  = (state == ST_IDLE) || (state_nxt != state) || bit_end;
    assign bit_smp  = (state == ST_BITS) && bit_end;
    assign stop_smp = (state == ST_STOP) && bit_end;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state   <= ST_IDLE;
            bit_cnt <= '0;
            bit_idx <= '0;
        end else begin
            state <= state_nxt;
            if (cnt_clr) begin
                bit_cnt <= '0;
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
            end
            if (state == ST_START) begin
                bit_idx <= '0;
            end else if (bit_smp) begin
                bit_idx <= bit_idx + 1'b1;
            end
        end
    end

    //====================
    // payload and parity
    //====================
    // msb first and the parity bit is not shifted in
    always_ff @(posedge i_clk) begin
        if (bit_smp && bit_idx < IDX_W'(PAY_W)) begin
            shift_q <= {shift_q[PAY_W-2:0], rxd_s};
        end
    end

    // even parity over cmd, data and the parity bit itself
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            parity_acc <= 1'b0;
        end else if (state == ST_START) begin
            parity_acc <= 1'b0;
        end else if (bit_smp) begin
            parity_acc <= parity_acc ^ rxd_s;
        end
    end

    //====================
    // frame output
    //====================
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            rx.ack <= 1'b0;
        end else begin
            rx.ack <= stop_smp;
        end
    end

    always_ff @(posedge i_clk) begin
        if (stop_smp) begin
            rx.cmd    <= shift_q[PAY_W-1 -: lv_pkg::OWT_CMD_BIT_NUM];
            rx.data   <= shift_q[lv_pkg::OWT_ADCD_BIT_NUM-1:0];
            rx.status <= parity_acc | ~rxd_s;
        end
    end

endmodule

// ==== owt_rx_if.sv ====
`timescale 1ns/1ps

interface owt_rx_if;

    // one-cycle pulse per received frame
    logic              ack;
    // cmd, data and status hold until the next frame
    lv_pkg::owt_cmd_t  cmd;
    lv_pkg::owt_data_t data;
    // 1 on parity error or bad stop bit
    logic              status;

    modport rx (
        output ack,
        output cmd,
        output data,
        output status
    );

    modport sink (
        input ack,
        input cmd,
        input data,
        input status
    );

endinterface

// ==== lv_pkg.sv ====
package lv_pkg;

    //====================
    // frame field widths
    //====================
    // cmd MSB is the write flag and the low bits hold the address
    localparam int OWT_CMD_BIT_NUM  = 8;
    localparam int OWT_ADCD_BIT_NUM = 20;

    //====================
    // register widths
    //====================
    localparam int REG_DW    = 10;
    localparam int ADC_DW    = 10;
    localparam int REG_AW    = 7;
    localparam int ERR_CNT_W = 8;

    typedef logic [OWT_CMD_BIT_NUM-1:0]  owt_cmd_t;
    typedef logic [OWT_ADCD_BIT_NUM-1:0] owt_data_t;
    typedef logic [REG_DW-1:0]           reg_data_t;
    typedef logic [ADC_DW-1:0]           adc_data_t;
    typedef logic [REG_AW-1:0]           reg_addr_t;
    typedef logic [ERR_CNT_W-1:0]        err_cnt_t;

    //====================
    // shadow register map
    //====================
    // hv status block
    localparam reg_addr_t ADDR_STATUS1 = 7'h08;
    localparam reg_addr_t ADDR_STATUS2 = 7'h0A;
    localparam reg_addr_t ADDR_STATUS3 = 7'h0C;
    localparam reg_addr_t ADDR_STATUS4 = 7'h0D;

    // hv bist results
    localparam reg_addr_t ADDR_BIST1 = 7'h14;
    localparam reg_addr_t ADDR_BIST2 = 7'h15;

    // one frame carries both adc samples
    localparam reg_addr_t ADDR_ADC = 7'h1F;

endpackage
